//--- common/dtls_rx_pkg.sv
package dtls_rx_pkg;

    // beat geometry
    localparam int BEAT_BYTES     = 8;
    localparam int DATA_W         = BEAT_BYTES * 8;
    localparam int DTLS_HDR_BYTES = 13;

    // header octets that spill into the second beat, equal to the realign shift
    localparam int SHIFT_BYTES = DTLS_HDR_BYTES - BEAT_BYTES;
    // octets carried over from the saved beat into the low lanes
    localparam int SAVE_BYTES  = BEAT_BYTES - SHIFT_BYTES;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [BEAT_BYTES-1:0] keep_t;
    typedef logic [15:0]           len_t;
    typedef logic [15:0]           port_t;
    typedef logic [47:0]           seqnum_t;

    typedef struct packed {
        port_t       src_port;
        port_t       dest_port;
        len_t        length;
        logic [15:0] checksum;
    } udp_hdr_t;

    typedef struct packed {
        udp_hdr_t    udp;
        logic [7:0]  rec_type;
        logic [15:0] version;
        logic [15:0] epoch;
        seqnum_t     seqnum;
        len_t        length;
    } dtls_hdr_t;

    // lane i carries octet i of the beat
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_HEADER,
        READ_PAYLOAD
    } rx_state_e;

    // number of set lanes counted up from lane 0
    function automatic logic [3:0] keep_count(keep_t k);
        logic [3:0] n;
        logic       run;
        n   = '0;
        run = 1'b1;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            if (run && k[i]) begin
                n = n + 4'd1;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

endpackage

//--- hw/axis_skid_buffer.sv
`timescale 1ns/1ns

module axis_skid_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  dtls_rx_pkg::axis_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic                    in_ready_early,
    output dtls_rx_pkg::axis_beat_t m_beat,
    output logic                    m_valid,
    input  logic                    m_ready
);
    import dtls_rx_pkg::*;

    axis_beat_t temp_beat;
    logic       temp_valid;
    logic       m_valid_next;
    logic       temp_valid_next;
    logic       load_out;
    logic       load_temp;
    logic       temp_to_out;

    // ready next cycle if the sink takes a beat or nothing is held
    assign in_ready_early = m_ready || (!temp_valid && !m_valid);

    always_comb begin
        m_valid_next    = m_valid;
        temp_valid_next = temp_valid;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;

        if (in_ready) begin
            if (m_ready || !m_valid) begin
                m_valid_next = in_valid;
                load_out     = 1'b1;
            end else begin
                // sink stalled, park the beat
                temp_valid_next = in_valid;
                load_temp       = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_next    = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            m_valid    <= m_valid_next;
            temp_valid <= temp_valid_next;
            in_ready   <= in_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            m_beat <= in_beat;
        end else if (temp_to_out) begin
            m_beat <= temp_beat;
        end
        if (load_temp) begin
            temp_beat <= in_beat;
        end
    end

endmodule

//--- hw/realign/payload_realign.sv
`timescale 1ns/1ns

module payload_realign (
    input  logic                    clk,
    input  logic                    rst,
    input  dtls_rx_pkg::axis_beat_t s_beat,
    input  logic                    s_valid,
    input  logic                    accept,
    input  logic                    flush,
    output dtls_rx_pkg::axis_beat_t sh_beat,
    output logic                    sh_valid,
    output logic                    sh_hold
);
    import dtls_rx_pkg::*;

    data_t save_data;
    keep_t save_keep;
    logic  save_user;
    logic  extra;
    logic  defer;

    // last beat has octets that do not fit after the carried lanes
    assign defer   = s_beat.last && (s_beat.keep[BEAT_BYTES-1:SHIFT_BYTES] != '0);
    assign sh_hold = extra;

    always_comb begin
        sh_beat.data[SAVE_BYTES*8-1:0] = save_data[DATA_W-1:SHIFT_BYTES*8];
        sh_beat.keep[SAVE_BYTES-1:0]   = save_keep[BEAT_BYTES-1:SHIFT_BYTES];
        if (extra) begin
            // flush beat of saved octets that ends the frame
            sh_beat.data[DATA_W-1:SAVE_BYTES*8]   = '0;
            sh_beat.keep[BEAT_BYTES-1:SAVE_BYTES] = '0;
            sh_beat.last                          = 1'b1;
            sh_beat.user                          = save_user;
            sh_valid                              = 1'b1;
        end else begin
            sh_beat.data[DATA_W-1:SAVE_BYTES*8]   = s_beat.data[SHIFT_BYTES*8-1:0];
            sh_beat.keep[BEAT_BYTES-1:SAVE_BYTES] = s_beat.keep[SHIFT_BYTES-1:0];
            sh_beat.last                          = s_beat.last && !defer;
            sh_beat.user                          = s_beat.user && !defer;
            sh_valid                              = s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            extra <= 1'b0;
        end else if (flush) begin
            extra <= 1'b0;
        end else if (accept) begin
            extra <= defer;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            save_data <= s_beat.data;
            save_keep <= s_beat.keep;
            save_user <= s_beat.user;
        end
    end

endmodule

//--- hw/rx_ctrl/dtls_rx_ctrl.sv
`timescale 1ns/1ns

module dtls_rx_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  dtls_rx_pkg::udp_hdr_t   s_hdr,
    input  logic                    s_valid,
    output logic                    s_ready,
    input  dtls_rx_pkg::axis_beat_t s_beat,
    output logic                    accept,
    output logic                    flush,
    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output dtls_rx_pkg::dtls_hdr_t  m_hdr,
    input  dtls_rx_pkg::axis_beat_t sh_beat,
    input  logic                    sh_valid,
    input  logic                    sh_hold,
    output dtls_rx_pkg::axis_beat_t in_beat,
    output logic                    in_valid,
    input  logic                    in_ready,
    input  logic                    in_ready_early,
    output logic                    busy,
    output logic                    err_hdr_early,
    output logic                    err_payload_early
);
    import dtls_rx_pkg::*;

    rx_state_e state;
    rx_state_e state_next;
    logic      hdr_beat;
    len_t      rem_len;
    len_t      rem_len_next;
    len_t      beat_len;
    logic      s_hdr_ready_next;
    logic      s_ready_next;
    logic      m_hdr_valid_next;
    logic      err_hdr_next;
    logic      err_payload_next;
    logic      store_udp;
    logic      store_word0;
    logic      store_word1;
    logic      fwd;
    logic      short_frame;

    assign accept   = s_valid && s_ready;
    assign beat_len = len_t'(keep_count(sh_beat.keep));

    // an extra flush beat goes out on its own, any other beat only when it is accepted
    assign in_valid    = (state == READ_PAYLOAD) && sh_valid && (sh_hold || s_ready);
    assign fwd         = in_valid && in_ready;
    assign short_frame = sh_beat.last && (beat_len < rem_len);

    always_comb begin
        in_beat      = sh_beat;
        in_beat.user = sh_beat.user || short_frame;
    end

    always_comb begin
        state_next       = state;
        s_hdr_ready_next = 1'b0;
        s_ready_next     = 1'b0;
        m_hdr_valid_next = m_hdr_valid && !m_hdr_ready;
        rem_len_next     = rem_len;
        err_hdr_next     = 1'b0;
        err_payload_next = 1'b0;
        store_udp        = 1'b0;
        store_word0      = 1'b0;
        store_word1      = 1'b0;
        flush            = 1'b0;

        case (state)
            IDLE: begin
                flush            = 1'b1;
                s_hdr_ready_next = !m_hdr_valid_next;
                if (s_hdr_valid && s_hdr_ready) begin
                    s_hdr_ready_next = 1'b0;
                    s_ready_next     = 1'b1;
                    store_udp        = 1'b1;
                    state_next       = READ_HEADER;
                end
            end
            READ_HEADER: begin
                s_ready_next = 1'b1;
                if (accept) begin
                    // frame ends before the 13 header octets are complete
                    if (sh_beat.last || (s_beat.last && !hdr_beat)) begin
                        err_hdr_next     = 1'b1;
                        flush            = 1'b1;
                        s_ready_next     = 1'b0;
                        s_hdr_ready_next = !m_hdr_valid_next;
                        state_next       = IDLE;
                    end else if (!hdr_beat) begin
                        store_word0 = 1'b1;
                    end else begin
                        store_word1      = 1'b1;
                        rem_len_next     = {s_beat.data[31:24], s_beat.data[39:32]};
                        m_hdr_valid_next = 1'b1;
                        // a last beat here can still leave a flush beat pending
                        s_ready_next     = in_ready_early && !s_beat.last;
                        state_next       = READ_PAYLOAD;
                    end
                end
            end
            READ_PAYLOAD: begin
                s_ready_next = in_ready_early && !sh_hold && !(accept && s_beat.last);
                if (fwd) begin
                    rem_len_next = (beat_len < rem_len) ? rem_len - beat_len : '0;
                    if (sh_beat.last) begin
                        err_payload_next = short_frame;
                        flush            = 1'b1;
                        s_ready_next     = 1'b0;
                        s_hdr_ready_next = !m_hdr_valid_next;
                        state_next       = IDLE;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            hdr_beat          <= 1'b0;
            s_hdr_ready       <= 1'b0;
            s_ready           <= 1'b0;
            m_hdr_valid       <= 1'b0;
            busy              <= 1'b0;
            err_hdr_early     <= 1'b0;
            err_payload_early <= 1'b0;
        end else begin
            state             <= state_next;
            s_hdr_ready       <= s_hdr_ready_next;
            s_ready           <= s_ready_next;
            m_hdr_valid       <= m_hdr_valid_next;
            busy              <= (state_next != IDLE);
            err_hdr_early     <= err_hdr_next;
            err_payload_early <= err_payload_next;
            if (store_udp) begin
                hdr_beat <= 1'b0;
            end else if (store_word0) begin
                hdr_beat <= 1'b1;
            end
        end
    end

    // record header fields, big-endian from payload octet 0
    always_ff @(posedge clk) begin
        rem_len <= rem_len_next;
        if (store_udp) begin
            m_hdr.udp <= s_hdr;
        end
        if (store_word0) begin
            m_hdr.rec_type      <= s_beat.data[7:0];
            m_hdr.version       <= {s_beat.data[15:8], s_beat.data[23:16]};
            m_hdr.epoch         <= {s_beat.data[31:24], s_beat.data[39:32]};
            m_hdr.seqnum[47:24] <= {s_beat.data[47:40], s_beat.data[55:48], s_beat.data[63:56]};
        end
        if (store_word1) begin
            m_hdr.seqnum[23:0] <= {s_beat.data[7:0], s_beat.data[15:8], s_beat.data[23:16]};
            m_hdr.length       <= {s_beat.data[31:24], s_beat.data[39:32]};
        end
    end

endmodule

//--- hw/dtls_rx.sv
`timescale 1ns/1ns

module dtls_rx (
    input  logic                    clk,
    input  logic                    rst,

    // udp frame in
    input  logic                    s_hdr_valid,
    output logic                    s_hdr_ready,
    input  dtls_rx_pkg::udp_hdr_t   s_hdr,
    input  logic                    s_valid,
    output logic                    s_ready,
    input  dtls_rx_pkg::axis_beat_t s_beat,

    // dtls record out
    output logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    output dtls_rx_pkg::dtls_hdr_t  m_hdr,
    output logic                    m_valid,
    input  logic                    m_ready,
    output dtls_rx_pkg::axis_beat_t m_beat,

    output logic                    busy,
    output logic                    err_hdr_early,
    output logic                    err_payload_early
);
    import dtls_rx_pkg::*;

    logic       accept;
    logic       flush;
    axis_beat_t sh_beat;
    logic       sh_valid;
    logic       sh_hold;
    axis_beat_t in_beat;
    logic       in_valid;
    logic       in_ready;
    logic       in_ready_early;

    dtls_rx_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .s_hdr_valid       (s_hdr_valid),
        .s_hdr_ready       (s_hdr_ready),
        .s_hdr             (s_hdr),
        .s_valid           (s_valid),
        .s_ready           (s_ready),
        .s_beat            (s_beat),
        .accept            (accept),
        .flush             (flush),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_hdr             (m_hdr),
        .sh_beat           (sh_beat),
        .sh_valid          (sh_valid),
        .sh_hold           (sh_hold),
        .in_beat           (in_beat),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .in_ready_early    (in_ready_early),
        .busy              (busy),
        .err_hdr_early     (err_hdr_early),
        .err_payload_early (err_payload_early)
    );

    payload_realign u_realign (
        .clk      (clk),
        .rst      (rst),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .accept   (accept),
        .flush    (flush),
        .sh_beat  (sh_beat),
        .sh_valid (sh_valid),
        .sh_hold  (sh_hold)
    );

    axis_skid_buffer u_skid (
        .clk            (clk),
        .rst            (rst),
        .in_beat        (in_beat),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_ready_early (in_ready_early),
        .m_beat         (m_beat),
        .m_valid        (m_valid),
        .m_ready        (m_ready)
    );

endmodule

//--- test/dtls_rx_checker.sv
`timescale 1ns/1ns

module dtls_rx_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s_hdr_ready,
    input  logic                    s_valid,
    input  logic                    s_ready,
    input  logic                    m_hdr_valid,
    input  logic                    m_hdr_ready,
    input  dtls_rx_pkg::dtls_hdr_t  m_hdr,
    input  logic                    m_valid,
    input  logic                    m_ready,
    input  dtls_rx_pkg::axis_beat_t m_beat,
    input  logic                    busy,
    input  logic                    err_hdr_early,
    input  logic                    err_payload_early
);
    import dtls_rx_pkg::*;

    dtls_hdr_t  exp_hdrs[$];
    axis_beat_t exp_beats[$];
    int         errors = 0;
    int         hdr_pulses = 0;
    int         payload_pulses = 0;
    int         hdr_count = 0;
    int         beat_count = 0;
    logic       rst_q = 1'b1;

    always @(posedge clk) begin
        dtls_hdr_t  eh;
        axis_beat_t eb;
        axis_beat_t act;
        rst_q <= rst;
        if (rst_q && !rst && busy) begin
            errors++;
            $display("busy is high straight after reset");
        end
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_hdrs.size() == 0) begin
                    errors++;
                    $display("header came out with none pending");
                end else begin
                    eh = exp_hdrs.pop_front();
                    if (m_hdr !== eh) begin
                        errors++;
                        $display("** Error hdr_fields #%0d: expected %h actual %h",
                                 hdr_count, eh, m_hdr);
                    end
                    hdr_count++;
                end
            end
            if (m_valid && m_ready) begin
                if (exp_beats.size() == 0) begin
                    errors++;
                    $display("payload beat came out with none pending");
                end else begin
                    eb  = exp_beats.pop_front();
                    act = m_beat;
                    // lanes outside keep carry no octet
                    for (int l = 0; l < BEAT_BYTES; l++) begin
                        if (!m_beat.keep[l]) begin
                            act.data[8*l +: 8] = 8'h00;
                        end
                    end
                    if (act !== eb) begin
                        errors++;
                        $display("** Error payload_beat #%0d: expected %h actual %h",
                                 beat_count, eb, act);
                    end
                    beat_count++;
                end
            end
            if (err_hdr_early) begin
                hdr_pulses++;
            end
            if (err_payload_early) begin
                payload_pulses++;
            end
            if (s_valid && s_ready && !busy) begin
                errors++;
                $display("busy is low while an input beat is accepted");
            end
            if (s_hdr_ready && busy) begin
                errors++;
                $display("busy is high while waiting for the next frame");
            end
        end
    end

endmodule

//--- test/tb_dtls_rx.sv
`timescale 1ns/1ns

module tb_dtls_rx;
    import dtls_rx_pkg::*;

    localparam int NUM_FRAMES = 27;
    localparam int MAX_OCTETS = 96;

    logic       clk;
    logic       rst;
    logic       s_hdr_valid;
    logic       s_hdr_ready;
    udp_hdr_t   s_hdr;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t s_beat;
    logic       m_hdr_valid;
    logic       m_hdr_ready;
    dtls_hdr_t  m_hdr;
    logic       m_valid;
    logic       m_ready;
    axis_beat_t m_beat;
    logic       busy;
    logic       err_hdr_early;
    logic       err_payload_early;

    logic [7:0]  oct [0:MAX_OCTETS-1];
    int          frame_len [0:NUM_FRAMES-1];
    logic [31:0] stim_seed;
    logic [31:0] rdy_seed;
    int          exp_hdr_errs;
    int          exp_payload_errs;
    int          cycle_limit;
    int          cycles;

    dtls_rx UUT (
        .clk               (clk),
        .rst               (rst),
        .s_hdr_valid       (s_hdr_valid),
        .s_hdr_ready       (s_hdr_ready),
        .s_hdr             (s_hdr),
        .s_valid           (s_valid),
        .s_ready           (s_ready),
        .s_beat            (s_beat),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_hdr             (m_hdr),
        .m_valid           (m_valid),
        .m_ready           (m_ready),
        .m_beat            (m_beat),
        .busy              (busy),
        .err_hdr_early     (err_hdr_early),
        .err_payload_early (err_payload_early)
    );

    dtls_rx_checker u_checker (
        .clk               (clk),
        .rst               (rst),
        .s_hdr_ready       (s_hdr_ready),
        .s_valid           (s_valid),
        .s_ready           (s_ready),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_hdr             (m_hdr),
        .m_valid           (m_valid),
        .m_ready           (m_ready),
        .m_beat            (m_beat),
        .busy              (busy),
        .err_hdr_early     (err_hdr_early),
        .err_payload_early (err_payload_early)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_step(stim_seed);
        return stim_seed;
    endfunction

    // 1 cuts the header short, 2 is shorter than its record length
    function automatic int frame_kind(input int idx);
        if (idx % 7 == 3) begin
            return 1;
        end else if (idx % 7 == 5) begin
            return 2;
        end
        return 0;
    endfunction

    // expected header, record payload beats and error pulses of one frame
    function automatic void ref_model(input int n, input len_t dlen, input udp_hdr_t udp);
        dtls_hdr_t  h;
        axis_beat_t b;
        int         p;
        if (n <= 12) begin
            exp_hdr_errs++;
            return;
        end
        h.udp      = udp;
        h.rec_type = oct[0];
        h.version  = {oct[1], oct[2]};
        h.epoch    = {oct[3], oct[4]};
        h.seqnum   = {oct[5], oct[6], oct[7], oct[8], oct[9], oct[10]};
        h.length   = {oct[11], oct[12]};
        u_checker.exp_hdrs.push_back(h);
        p = n - DTLS_HDR_BYTES;
        if (p < int'(dlen)) begin
            exp_payload_errs++;
        end
        for (int i = 0; i < p; i += BEAT_BYTES) begin
            b = '0;
            for (int l = 0; l < BEAT_BYTES; l++) begin
                if (i + l < p) begin
                    b.data[8*l +: 8] = oct[DTLS_HDR_BYTES + i + l];
                    b.keep[l]        = 1'b1;
                end
            end
            b.last = (i + BEAT_BYTES >= p);
            b.user = b.last && (p < int'(dlen));
            u_checker.exp_beats.push_back(b);
        end
    endfunction

    task automatic send_frame(input int idx);
        int          n;
        int          plen;
        logic [31:0] r;
        udp_hdr_t    udp;
        n = frame_len[idx];
        for (int i = 0; i < n; i++) begin
            r      = next_rand();
            oct[i] = r[23:16];
        end
        plen = (n > DTLS_HDR_BYTES) ? n - DTLS_HDR_BYTES : 0;
        if (frame_kind(idx) == 2) begin
            r    = next_rand();
            plen = plen + 1 + int'(r % 20);
        end
        oct[11]        = plen[15:8];
        oct[12]        = plen[7:0];
        r              = next_rand();
        udp.src_port   = r[31:16];
        udp.dest_port  = r[15:0];
        r              = next_rand();
        udp.length     = len_t'(n + 8);
        udp.checksum   = r[31:16];
        ref_model(n, len_t'(plen), udp);

        s_hdr       = udp;
        s_hdr_valid = 1'b1;
        while (!s_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_hdr_valid = 1'b0;

        for (int b = 0; b < (n + 7) / 8; b++) begin
            r = next_rand();
            if (r[30:28] == 3'd0) begin
                // idle gap on the input stream
                s_valid = 1'b0;
                @(negedge clk);
            end
            s_beat = '0;
            for (int l = 0; l < BEAT_BYTES; l++) begin
                if (8 * b + l < n) begin
                    s_beat.data[8*l +: 8] = oct[8*b + l];
                    s_beat.keep[l]        = 1'b1;
                end
            end
            s_beat.last = (8 * b + 8 >= n);
            s_valid     = 1'b1;
            while (!s_ready) @(negedge clk);
            @(negedge clk);
        end
        s_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // output back-pressure pattern
    initial begin
        m_ready     = 1'b0;
        m_hdr_ready = 1'b0;
        rdy_seed    = lcg_step(32'h5d0c);
        forever begin
            @(negedge clk);
            rdy_seed    = lcg_step(rdy_seed);
            m_ready     = (rdy_seed[17:16] != 2'd0);
            m_hdr_ready = (rdy_seed[25:24] != 2'd0);
        end
    end

    initial begin
        cycles = 0;
        while (cycle_limit == 0 || cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, frames did not drain", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          total_beats;
        int          fails;
        rst              = 1'b1;
        s_hdr_valid      = 1'b0;
        s_hdr            = '0;
        s_valid          = 1'b0;
        s_beat           = '0;
        stim_seed        = 32'h5d0c;
        exp_hdr_errs     = 0;
        exp_payload_errs = 0;
        total_beats      = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            r            = next_rand();
            frame_len[i] = (frame_kind(i) == 1) ? 1 + int'(r % 12) : 14 + int'(r % 67);
            total_beats  = total_beats + (frame_len[i] + 7) / 8;
        end
        cycle_limit = 40 * total_beats + 200;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i);
        end
        while (u_checker.exp_beats.size() != 0 || u_checker.exp_hdrs.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        fails = u_checker.errors;
        if (u_checker.hdr_pulses != exp_hdr_errs) begin
            $display("header early error pulses do not match the short frames sent");
            fails++;
        end
        if (u_checker.payload_pulses != exp_payload_errs) begin
            $display("payload early error pulses do not match the short records sent");
            fails++;
        end
        $display("errors %0d, hdr_early %0d of %0d, payload_early %0d of %0d",
                 fails, u_checker.hdr_pulses, exp_hdr_errs,
                 u_checker.payload_pulses, exp_payload_errs);
        if (fails != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

//--- verilog.f
common/dtls_rx_pkg.sv
hw/axis_skid_buffer.sv
hw/realign/payload_realign.sv
hw/rx_ctrl/dtls_rx_ctrl.sv
hw/dtls_rx.sv
test/dtls_rx_checker.sv
test/tb_dtls_rx.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dtls_rx -f verilog.f -o sim_dtls_rx
./obj_dir/sim_dtls_rx | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
